//--- verilog/patch_pkg.sv
`default_nettype none

package patch_pkg;

  typedef logic [31:0]        addr_t;       // byte address, shared memory
  typedef logic [31:0]        word_t;       // wide port data
  typedef logic [7:0]         pixel_t;      // palette index or patch byte
  typedef logic signed [15:0] coord_t;      // screen coord or patch offset
  typedef logic [2:0]         param_idx_t;  // host slot number

  localparam int default_screen_width = 320;    // row stride in bytes
  localparam int default_screen_size  = 64000;  // bytes per screen
  localparam int num_screens          = 5;      // valid scrn 0..4

  typedef enum logic [2:0] {
    w_idle,       // waiting for go
    w_rd_size,    // width/height word
    w_rd_offs,    // left/top offset word
    w_rd_colofs,  // column offset entry
    w_rd_post,    // post header or terminator
    w_copy        // copier busy with a post
  } walker_state_t;

  typedef enum logic [1:0] {
    c_idle,   // waiting for copy_start
    c_read,   // byte read from patch
    c_write   // byte write to framebuffer
  } copier_state_t;

endpackage

`default_nettype wire

//--- verilog/patch_param_bank.sv
`timescale 1ns/1ps
`default_nettype none

module patch_param_bank #(
  parameter int screen_size = patch_pkg::default_screen_size
) (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   param_write,  // one cycle slot store
  input  wire patch_pkg::param_idx_t  param_index,
  input  wire patch_pkg::word_t       param_data,
  input  wire logic                   start,        // host pulse
  input  wire logic                   busy,         // from walker
  output logic                        go,           // one cycle, accepted start
  output patch_pkg::coord_t           origin_x,
  output patch_pkg::coord_t           origin_y,
  output patch_pkg::addr_t            screen_base,
  output patch_pkg::addr_t            patch_base
);
  import patch_pkg::*;

  localparam param_idx_t slot_x       = 3'd1;
  localparam param_idx_t slot_y       = 3'd2;
  localparam param_idx_t slot_scrn    = 3'd3;
  localparam param_idx_t slot_screens = 3'd4;
  localparam param_idx_t slot_patch   = 3'd5;

  coord_t x_slot, y_slot;       // host copies, may change mid draw
  word_t  scrn_slot;
  addr_t  screens_slot, patch_slot;
  addr_t  scrn_offset;          // comb, scrn * screen_size
  logic   accept;               // start while idle

  assign accept = start && !busy;

  // out of range screen index draws on screen 0
  always_comb begin
    if (scrn_slot < word_t'(num_screens))
      scrn_offset = addr_t'(scrn_slot[2:0]) * addr_t'(screen_size);
    else
      scrn_offset = '0;
  end

  always_ff @(posedge clk) begin
    if (param_write) begin
      case (param_index)
        slot_x:       x_slot <= coord_t'(param_data[15:0]);
        slot_y:       y_slot <= coord_t'(param_data[15:0]);
        slot_scrn:    scrn_slot <= param_data;
        slot_screens: screens_slot <= param_data;
        slot_patch:   patch_slot <= param_data;
        default:      ;                                 // unused slots dropped
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      go <= 1'b0;
    end else begin
      go <= accept;
      if (accept) begin                                 // working copy for this draw
        origin_x    <= x_slot;
        origin_y    <= y_slot;
        screen_base <= screens_slot + scrn_offset;
        patch_base  <= patch_slot;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/wide_read_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module wide_read_aligner (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              rd_start,          // one cycle request
  input  wire patch_pkg::addr_t  rd_addr,           // any byte address
  input  wire logic              w_mem_waitrequest,
  input  wire patch_pkg::word_t  w_mem_readdata,
  output logic                   rd_done,           // one cycle, rd_word valid
  output patch_pkg::word_t       rd_word,
  output patch_pkg::addr_t       w_mem_address,
  output logic                   w_mem_read
);
  import patch_pkg::*;

  typedef enum logic [1:0] {
    a_idle,
    a_first,    // aligned word holding the low bytes
    a_gap,      // read dropped for one cycle
    a_second    // following word, high bytes
  } aligner_state_t;

  aligner_state_t state;
  logic [1:0]     byte_ofs;       // rd_addr[1:0] of the request
  word_t          lo_word;        // first word kept for the merge
  logic [63:0]    pair;           // comb, both words little endian
  word_t          merged;         // comb, shifted down by byte_ofs

  assign w_mem_read = (state == a_first) || (state == a_second);

  assign pair   = {w_mem_readdata, lo_word};
  assign merged = word_t'(pair >> {byte_ofs, 3'b000});  // bytes to bits

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= a_idle;
      rd_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      case (state)
        a_idle: begin
          if (rd_start) begin
            w_mem_address <= {rd_addr[31:2], 2'b00};    // word aligned
            byte_ofs      <= rd_addr[1:0];
            state         <= a_first;
          end
        end
        a_first: begin
          if (!w_mem_waitrequest) begin
            if (byte_ofs == 2'd0) begin                 // aligned, single read
              rd_word <= w_mem_readdata;
              rd_done <= 1'b1;
              state   <= a_idle;
            end else begin
              lo_word       <= w_mem_readdata;
              w_mem_address <= w_mem_address + addr_t'(4);
              state         <= a_gap;
            end
          end
        end
        a_gap: begin
          state <= a_second;                            // read low here
        end
        a_second: begin
          if (!w_mem_waitrequest) begin
            rd_word <= merged;
            rd_done <= 1'b1;
            state   <= a_idle;
          end
        end
        default: state <= a_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/patch_walker.sv
`timescale 1ns/1ps
`default_nettype none

module patch_walker #(
  parameter int screen_width = patch_pkg::default_screen_width
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              go,            // draw request from bank
  input  wire patch_pkg::coord_t origin_x,      // stable while busy
  input  wire patch_pkg::coord_t origin_y,
  input  wire patch_pkg::addr_t  screen_base,
  input  wire patch_pkg::addr_t  patch_base,
  input  wire logic              rd_done,
  input  wire patch_pkg::word_t  rd_word,
  input  wire logic              copy_done,
  output logic                   busy,
  output logic                   rd_start,      // one cycle
  output patch_pkg::addr_t       rd_addr,
  output logic                   copy_start,    // one cycle
  output patch_pkg::addr_t       copy_src,
  output patch_pkg::addr_t       copy_dest,
  output patch_pkg::pixel_t      copy_count
);
  import patch_pkg::*;

  walker_state_t      state;
  logic [15:0]        width;          // columns in the patch
  logic [15:0]        col;            // current column
  logic [15:0]        col_next;       // comb
  addr_t              desttop;        // framebuffer top of current column
  addr_t              post_addr;      // current post header
  coord_t             left_ofs;       // comb, from offset word
  coord_t             top_ofs;
  logic signed [31:0] adj_x;          // comb, x - leftoffset
  logic signed [31:0] adj_y;          // comb, y - topoffset
  pixel_t             post_delta;     // comb, from post header
  pixel_t             post_len;

  assign busy = go || (state != w_idle);  // high from the cycle after start

  assign left_ofs   = coord_t'(rd_word[15:0]);
  assign top_ofs    = coord_t'(rd_word[31:16]);
  assign adj_x      = origin_x - left_ofs;    // signed, may go negative
  assign adj_y      = origin_y - top_ofs;
  assign post_delta = rd_word[7:0];
  assign post_len   = rd_word[15:8];
  assign col_next   = col + 16'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= w_idle;
      rd_start   <= 1'b0;
      copy_start <= 1'b0;
    end else begin
      rd_start   <= 1'b0;
      copy_start <= 1'b0;
      case (state)
        w_idle: begin
          if (go) begin
            rd_start <= 1'b1;
            rd_addr  <= patch_base;                       // width, height
            state    <= w_rd_size;
          end
        end
        w_rd_size: begin
          if (rd_done) begin
            width    <= rd_word[15:0];                    // height unused
            rd_start <= 1'b1;
            rd_addr  <= patch_base + addr_t'(4);          // leftoffset, topoffset
            state    <= w_rd_offs;
          end
        end
        w_rd_offs: begin
          if (rd_done) begin
            // wraps mod 2^32, so negative offsets land as signed
            desttop <= screen_base + addr_t'(adj_y * screen_width) + addr_t'(adj_x);
            col     <= '0;
            if (width == 16'd0) begin
              state <= w_idle;                            // nothing to draw
            end else begin
              rd_start <= 1'b1;
              rd_addr  <= patch_base + addr_t'(8);        // columnofs[0]
              state    <= w_rd_colofs;
            end
          end
        end
        w_rd_colofs: begin
          if (rd_done) begin
            post_addr <= patch_base + rd_word;            // ofs relative to patch
            rd_start  <= 1'b1;
            rd_addr   <= patch_base + rd_word;
            state     <= w_rd_post;
          end
        end
        w_rd_post: begin
          if (rd_done) begin
            if (post_delta == 8'hff) begin                // end of column
              if (col_next == width) begin
                state <= w_idle;
              end else begin
                col      <= col_next;
                desttop  <= desttop + addr_t'(1);
                rd_start <= 1'b1;
                rd_addr  <= patch_base + addr_t'(8) + (addr_t'(col_next) << 2);
                state    <= w_rd_colofs;
              end
            end else begin
              copy_start <= 1'b1;
              copy_src   <= post_addr + addr_t'(3);       // skip header and pad
              copy_dest  <= desttop + addr_t'(post_delta) * addr_t'(screen_width);
              copy_count <= post_len;
              post_addr  <= post_addr + addr_t'(post_len) + addr_t'(4);
              state      <= w_copy;
            end
          end
        end
        w_copy: begin
          if (copy_done) begin
            rd_start <= 1'b1;
            rd_addr  <= post_addr;                        // next post header
            state    <= w_rd_post;
          end
        end
        default: state <= w_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/column_copier.sv
`timescale 1ns/1ps
`default_nettype none

module column_copier #(
  parameter int screen_width = patch_pkg::default_screen_width
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               copy_start,       // one cycle
  input  wire patch_pkg::addr_t   copy_src,         // first data byte of post
  input  wire patch_pkg::addr_t   copy_dest,        // top pixel in framebuffer
  input  wire patch_pkg::pixel_t  copy_count,       // post length, may be 0
  input  wire logic               mem_waitrequest,
  input  wire patch_pkg::pixel_t  mem_readdata,
  output logic                    copy_done,        // one cycle
  output patch_pkg::addr_t        mem_address,
  output logic                    mem_read,
  output logic                    mem_write,
  output patch_pkg::pixel_t       mem_writedata
);
  import patch_pkg::*;

  copier_state_t state;
  addr_t         src;           // next patch byte
  addr_t         dest;          // next framebuffer byte
  pixel_t        count;         // bytes left
  pixel_t        data;          // byte in flight

  assign mem_read      = (state == c_read);
  assign mem_write     = (state == c_write);
  assign mem_address   = (state == c_write) ? dest : src;  // steady while stalled
  assign mem_writedata = data;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= c_idle;
      copy_done <= 1'b0;
    end else begin
      copy_done <= 1'b0;
      case (state)
        c_idle: begin
          if (copy_start) begin
            src   <= copy_src;
            dest  <= copy_dest;
            count <= copy_count;
            if (copy_count == 8'd0)
              copy_done <= 1'b1;                 // empty post, no access
            else
              state <= c_read;
          end
        end
        c_read: begin
          if (!mem_waitrequest) begin
            data  <= mem_readdata;
            src   <= src + addr_t'(1);
            state <= c_write;
          end
        end
        c_write: begin
          if (!mem_waitrequest) begin
            dest  <= dest + addr_t'(screen_width);   // one row down
            count <= count - 8'd1;
            if (count == 8'd1) begin                 // last byte written
              copy_done <= 1'b1;
              state     <= c_idle;
            end else begin
              state <= c_read;
            end
          end
        end
        default: state <= c_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/patch_draw_top.sv
`timescale 1ns/1ps
`default_nettype none

module patch_draw_top #(
  parameter int screen_width = patch_pkg::default_screen_width,
  parameter int screen_size  = patch_pkg::default_screen_size
) (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   param_write,        // host slot store
  input  wire patch_pkg::param_idx_t  param_index,
  input  wire patch_pkg::word_t       param_data,
  input  wire logic                   start,
  output logic                        busy,
  output patch_pkg::addr_t            mem_address,        // byte port
  output logic                        mem_read,
  output logic                        mem_write,
  output patch_pkg::pixel_t           mem_writedata,
  input  wire logic                   mem_waitrequest,
  input  wire patch_pkg::pixel_t      mem_readdata,
  output patch_pkg::addr_t            w_mem_address,      // wide port, reads only
  output logic                        w_mem_read,
  input  wire logic                   w_mem_waitrequest,
  input  wire patch_pkg::word_t       w_mem_readdata
);
  import patch_pkg::*;

  logic   go;                           // bank to walker
  coord_t origin_x, origin_y;
  addr_t  screen_base, patch_base;
  logic   rd_start, rd_done;            // walker and aligner
  addr_t  rd_addr;
  word_t  rd_word;
  logic   copy_start, copy_done;        // walker and copier
  addr_t  copy_src, copy_dest;
  pixel_t copy_count;

  patch_param_bank #(.screen_size(screen_size)) bank_i (
    .clk, .reset, .param_write, .param_index, .param_data, .start, .busy,
    .go, .origin_x, .origin_y, .screen_base, .patch_base
  );

  patch_walker #(.screen_width(screen_width)) walker_i (
    .clk, .reset, .go, .origin_x, .origin_y, .screen_base, .patch_base,
    .rd_done, .rd_word, .copy_done, .busy, .rd_start, .rd_addr,
    .copy_start, .copy_src, .copy_dest, .copy_count
  );

  wide_read_aligner aligner_i (
    .clk, .reset, .rd_start, .rd_addr, .w_mem_waitrequest, .w_mem_readdata,
    .rd_done, .rd_word, .w_mem_address, .w_mem_read
  );

  column_copier #(.screen_width(screen_width)) copier_i (
    .clk, .reset, .copy_start, .copy_src, .copy_dest, .copy_count,
    .mem_waitrequest, .mem_readdata, .copy_done, .mem_address,
    .mem_read, .mem_write, .mem_writedata
  );

endmodule

`default_nettype wire

//--- tests/patch_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module patch_mem_model #(
  parameter int addr_bits = 19
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              pressure,           // random waitrequest on both ports
  input  wire logic              bd_write,           // preload path without handshake
  input  wire patch_pkg::addr_t  bd_addr,
  input  wire patch_pkg::pixel_t bd_data,
  input  wire patch_pkg::addr_t  mem_address,        // byte port
  input  wire logic              mem_read,
  input  wire logic              mem_write,
  input  wire patch_pkg::pixel_t mem_writedata,
  output logic                   mem_waitrequest,
  output patch_pkg::pixel_t      mem_readdata,
  input  wire patch_pkg::addr_t  w_mem_address,      // wide port for reads
  input  wire logic              w_mem_read,
  output logic                   w_mem_waitrequest,
  output patch_pkg::word_t       w_mem_readdata
);
  import patch_pkg::*;

  pixel_t      ram [0:(1 << addr_bits) - 1];  // shared by both ports
  addr_t       wr_addr [0:4095];             // byte port write log that wraps
  int          wr_count;                     // completed byte writes
  integer      seed = 32'h5dda;
  logic [31:0] rnd;

  // read data only while the read strobe is high, zero otherwise
  assign mem_readdata   = mem_read ? ram[mem_address[addr_bits-1:0]] : '0;
  assign w_mem_readdata = w_mem_read ?
                          {ram[{w_mem_address[addr_bits-1:2], 2'd3}],
                           ram[{w_mem_address[addr_bits-1:2], 2'd2}],
                           ram[{w_mem_address[addr_bits-1:2], 2'd1}],
                           ram[{w_mem_address[addr_bits-1:2], 2'd0}]} : '0;  // little endian

  always @(posedge clk) begin
    if (reset) begin
      mem_waitrequest   <= 1'b0;
      w_mem_waitrequest <= 1'b0;
      wr_count          <= 0;
    end else begin
      rnd = $random(seed);
      mem_waitrequest   <= pressure && rnd[0];   // about half the cycles stalled
      w_mem_waitrequest <= pressure && rnd[1];
      if (mem_write && !mem_waitrequest) begin   // write completes this edge
        ram[mem_address[addr_bits-1:0]] <= mem_writedata;
        wr_addr[wr_count[11:0]]         <= mem_address;
        wr_count                        <= wr_count + 1;
      end
    end
    if (bd_write)
      ram[bd_addr[addr_bits-1:0]] <= bd_data;     // preload and clear
  end

endmodule

`default_nettype wire

//--- tests/patch_draw_tb.sv
`timescale 1ns/1ps
`default_nettype none

module patch_draw_tb;
  import patch_pkg::*;

  localparam int     clk_period   = 40;
  localparam int     num_rows     = 10;
  localparam int     draw_budget  = 2000;           // worst case cycles per row, preload too
  localparam longint watchdog_ns  = longint'(16 + num_rows * draw_budget) * clk_period;
  localparam int     mem_bits     = 19;
  localparam addr_t  screens_addr = 32'h0000_1000;  // patches sit below this
  localparam coord_t poke_x       = 16'sd60;        // x slot value written mid draw

  typedef struct packed {
    logic [1:0] kind;       // patch shape
    addr_t      base;       // patch address
    coord_t     x;
    coord_t     y;
    logic [3:0] scrn;
    logic [3:0] gap;        // pad bytes between columns
    logic       pressure;   // random waitrequest
    logic       poke;       // rewrite x and pulse start mid draw
    logic       keep_x;     // x slot left from the previous poke
  } draw_row_t;

  logic       clk, reset, param_write, start, pressure, bd_write;
  param_idx_t param_index;
  word_t      param_data;
  addr_t      bd_addr;
  pixel_t     bd_data;
  logic       busy, mem_read, mem_write, mem_waitrequest;
  addr_t      mem_address, w_mem_address;
  pixel_t     mem_writedata, mem_readdata;
  logic       w_mem_read, w_mem_waitrequest;
  word_t      w_mem_readdata;

  draw_row_t  rows [num_rows];
  pixel_t     image [$];            // patch bytes of the current row
  pixel_t     expect_px [addr_t];   // reference framebuffer writes
  int         errors, runs;

  patch_draw_top #(
    .screen_width(default_screen_width), .screen_size(default_screen_size)
  ) dut_i (
    .clk, .reset, .param_write, .param_index, .param_data, .start, .busy,
    .mem_address, .mem_read, .mem_write, .mem_writedata, .mem_waitrequest,
    .mem_readdata, .w_mem_address, .w_mem_read, .w_mem_waitrequest, .w_mem_readdata
  );

  patch_mem_model #(.addr_bits(mem_bits)) mem_i (
    .clk, .reset, .pressure, .bd_write, .bd_addr, .bd_data,
    .mem_address, .mem_read, .mem_write, .mem_writedata, .mem_waitrequest,
    .mem_readdata, .w_mem_address, .w_mem_read, .w_mem_waitrequest, .w_mem_readdata
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: a draw did not finish within %0d cycles", draw_budget);
    $display("Test failed");
    $finish;
  end

  task automatic tick();            // drive and sample 2 ns after the edge
    @(posedge clk);
    #2;
  endtask

  task automatic write_param(input param_idx_t idx, input word_t data);
    param_write = 1'b1;
    param_index = idx;
    param_data  = data;
    tick();
    param_write = 1'b0;
  endtask

  task automatic backdoor_write(input addr_t addr, input pixel_t data);
    bd_write = 1'b1;
    bd_addr  = addr;
    bd_data  = data;
    tick();
    bd_write = 1'b0;
  endtask

  function automatic int le16(input int idx);
    return int'({image[idx + 1], image[idx]});
  endfunction

  function automatic int le16s(input int idx);     // signed offsets
    return int'($signed({image[idx + 1], image[idx]}));
  endfunction

  function automatic int le32(input int idx);
    return int'({image[idx + 3], image[idx + 2], image[idx + 1], image[idx]});
  endfunction

  task automatic put_le(input int idx, input int val, input int nbytes);
    for (int b = 0; b < nbytes; b++)
      image[idx + b] = pixel_t'(val >> (8 * b));
  endtask

  // lays out header, column table and post chains
  task automatic build_patch(input logic [1:0] kind, input int gap);
    int plist [$];                  // delta, length pairs, -1 closes a column
    int width, lofs, tofs, c, i, k, n;
    case (kind)
      2'd0: begin
        width = 1; lofs = 0; tofs = 0;
        plist = '{0, 5, -1};
      end
      2'd1: begin                   // empty posts and several posts per column
        width = 3; lofs = 1; tofs = 2;
        plist = '{2, 3, 10, 0, 12, 2, -1, 0, 0, -1, 1, 4, 8, 1, -1};
      end
      default: begin                // offsets larger than x and y
        width = 2; lofs = 30; tofs = 20;
        plist = '{3, 2, -1, 0, 3, 9, 2, -1};
      end
    endcase
    image.delete();
    for (i = 0; i < 8 + 4 * width; i++)
      image.push_back(8'h00);
    put_le(0, width, 2);
    put_le(2, 16, 2);               // height, not used by the engine
    put_le(4, lofs, 2);
    put_le(6, tofs, 2);
    c = 0;
    n = 50 * int'(kind);
    repeat (gap) image.push_back(8'hee);
    put_le(8, image.size(), 4);
    for (i = 0; i < plist.size(); i++) begin
      if (plist[i] < 0) begin
        image.push_back(8'hff);     // column end
        repeat (gap) image.push_back(8'hee);
        c++;
        if (c < width)
          put_le(8 + 4 * c, image.size(), 4);
      end else begin
        image.push_back(pixel_t'(plist[i]));
        image.push_back(pixel_t'(plist[i + 1]));
        image.push_back(8'h00);
        for (k = 0; k < plist[i + 1]; k++) begin
          n++;
          image.push_back(pixel_t'(n % 250 + 1));  // nonzero, cleared pixels differ
        end
        image.push_back(8'h00);
        i++;
      end
    end
  endtask

  function automatic addr_t expected_screen(input int scrn);
    if (scrn < num_screens)
      return screens_addr + addr_t'(scrn * default_screen_size);
    return screens_addr;            // out of range index, screen 0
  endfunction

  // walks the image by the layout rule, signed placement
  task automatic reference_draw(input addr_t sbase, input int x, input int y);
    int width, lofs, tofs, c, pos, k, delta, len;
    addr_t a;
    expect_px.delete();
    width = le16(0);
    lofs  = le16s(4);
    tofs  = le16s(6);
    for (c = 0; c < width; c++) begin
      pos = le32(8 + 4 * c);
      while (image[pos] != 8'hff) begin
        delta = int'(image[pos]);
        len   = int'(image[pos + 1]);
        for (k = 0; k < len; k++) begin
          a = sbase + addr_t'((y - tofs + delta + k) * default_screen_width + (x - lofs + c));
          expect_px[a] = image[pos + 3 + k];
        end
        pos += len + 4;
      end
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      tick();
      if (busy || mem_read || mem_write || w_mem_read) begin
        errors++;
        $display("Error at %0t: activity before start, busy=%b rd=%b wr=%b w_rd=%b",
                 $time, busy, mem_read, mem_write, w_mem_read);
      end
    end
  endtask

  task automatic run_row(input draw_row_t row);
    int x, log_start, n, i;
    logic [11:0] slot;
    addr_t a;
    x = row.keep_x ? int'(poke_x) : int'(row.x);
    build_patch(row.kind, int'(row.gap));
    reference_draw(expected_screen(int'(row.scrn)), x, int'(row.y));
    foreach (expect_px[p])
      backdoor_write(p, 8'h00);     // clear target pixels
    for (i = 0; i < image.size(); i++)
      backdoor_write(row.base + addr_t'(i), image[i]);
    pressure = row.pressure;
    if (!row.keep_x)
      write_param(3'd1, word_t'(int'(row.x)));
    write_param(3'd2, word_t'(int'(row.y)));
    write_param(3'd3, word_t'(row.scrn));
    write_param(3'd4, screens_addr);
    write_param(3'd5, row.base);
    log_start = mem_i.wr_count;
    start = 1'b1;
    tick();
    start = 1'b0;
    while (!busy) tick();
    if (row.poke) begin
      tick();
      write_param(3'd1, word_t'(int'(poke_x)));
      if (!busy) begin
        errors++;
        $display("Error at %0t: draw ended before the second start", $time);
      end
      start = 1'b1;                 // busy, so this start is dropped
      tick();
      start = 1'b0;
    end
    while (busy) tick();
    pressure = 1'b0;
    n = mem_i.wr_count - log_start;
    if (n != expect_px.num()) begin
      errors++;
      $display("Error at %0t: %0d byte writes, expected %0d", $time, n, expect_px.num());
    end
    for (i = 0; i < n; i++) begin
      slot = 12'(log_start + i);
      a    = mem_i.wr_addr[slot];
      if (!expect_px.exists(a)) begin
        errors++;
        $display("Error at %0t: stray byte write at %h", $time, a);
      end
    end
    foreach (expect_px[p]) begin
      if (mem_i.ram[p[mem_bits-1:0]] != expect_px[p]) begin
        errors++;
        $display("Error at %0t: pixel %h is %h, expected %h",
                 $time, p, mem_i.ram[p[mem_bits-1:0]], expect_px[p]);
      end
    end
    if (row.poke) begin
      repeat (4) begin
        tick();
        if (busy) begin
          errors++;
          $display("Error at %0t: start during a draw was accepted", $time);
        end
      end
    end
    runs++;
  endtask

  task automatic load_table();
    // kind, base, x, y, scrn, gap, pressure, poke, keep_x
    rows[0] = '{2'd0, 32'h100, 16'sd50,  16'sd10, 4'd0, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[1] = '{2'd1, 32'h200, 16'sd100, 16'sd40, 4'd1, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[2] = '{2'd1, 32'h301, 16'sd100, 16'sd40, 4'd1, 4'd3, 1'b0, 1'b0, 1'b0};
    rows[3] = '{2'd2, 32'h400, 16'sd10,  16'sd5,  4'd2, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[4] = '{2'd0, 32'h100, 16'sd7,   16'sd3,  4'd3, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[5] = '{2'd0, 32'h100, 16'sd7,   16'sd3,  4'd4, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[6] = '{2'd0, 32'h100, 16'sd7,   16'sd3,  4'd5, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[7] = '{2'd1, 32'h301, 16'sd100, 16'sd40, 4'd1, 4'd3, 1'b1, 1'b0, 1'b0};
    rows[8] = '{2'd2, 32'h402, 16'sd10,  16'sd5,  4'd2, 4'd1, 1'b1, 1'b1, 1'b0};
    rows[9] = '{2'd0, 32'h100, 16'sd0,   16'sd10, 4'd0, 4'd0, 1'b0, 1'b0, 1'b1};
  endtask

  initial begin
    int r;
    reset       = 1'b1;
    param_write = 1'b0;
    param_index = '0;
    param_data  = '0;
    start       = 1'b0;
    pressure    = 1'b0;
    bd_write    = 1'b0;
    bd_addr     = '0;
    bd_data     = '0;
    errors      = 0;
    runs        = 0;
    load_table();
    repeat (16) tick();
    reset = 1'b0;
    check_idle(8);
    for (r = 0; r < num_rows; r++)
      run_row(rows[r]);
    $display("Summary: %0d draws run, %0d errors", runs, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/patch_pkg.sv
verilog/patch_param_bank.sv
verilog/wide_read_aligner.sv
verilog/patch_walker.sv
verilog/column_copier.sv
verilog/patch_draw_top.sv
tests/patch_mem_model.sv
tests/patch_draw_tb.sv

//--- Makefile
# Verilator build and run for the patch drawing engine

VERILATOR ?= verilator
TOP       ?= patch_draw_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  := Test completed successfully

SOURCES := $(wildcard verilog/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
